// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_residual
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+verif
src/residual_pkg.sv
src/predictor_select.sv
src/residual_map.sv
src/near_control.sv
src/output_stage.sv
src/residual_top.sv
verif/tb_residual.sv

// ==== src/near_control.sv ====
module near_control
  import residual_pkg::*;
#(
  parameter int SAMPLE_W = residual_pkg::SAMPLE_W,
  parameter int NEAR_MAX = residual_pkg::NEAR_MAX
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               en_i,
  input  logic [RATIO_W-1:0] id_ratio_i,
  input  logic               en_upmode_i,
  input  near_step_e         up_mode_i,
  input  logic               en_fst_blo_i,
  input  logic               en_block_cnt_i,
  output logic [NEAR_W-1:0]  near_o
);

  localparam logic [NEAR_W-1:0] NEAR_CEIL = NEAR_W'(NEAR_MAX);

  logic [RATIO_W-1:0] ratio_q;
  logic               upmode_q;
  near_step_e         step_q;
  logic [NEAR_W-1:0]  near_q;
  logic [NEAR_W-1:0]  near_snap_q;
  logic [NEAR_W-1:0]  table_near;
  logic [NEAR_W-1:0]  stepped;

  // ceiling has to fit the threshold and the residual range
  if (NEAR_MAX >= (1 << NEAR_W) || NEAR_MAX >= (1 << SAMPLE_W)) begin : g_bad_ceiling
    $error("NEAR_MAX %0d out of range", NEAR_MAX);
  end

  // ratio and up-enable one cycle late
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ratio_q  <= RATIO_W'(1);
      upmode_q <= 1'b0;
    end else begin
      ratio_q  <= id_ratio_i;
      upmode_q <= en_upmode_i;
    end
  end

  // starting threshold per compression ratio
  always_comb begin
    case (ratio_q)
      RATIO_W'(1): table_near = NEAR_W'(0);
      RATIO_W'(4): table_near = NEAR_W'(8);
      RATIO_W'(8): table_near = NEAR_W'(20);
      default:     table_near = NEAR_W'(0);
    endcase
  end

  // one step per cycle, floor at zero and ceiling at NEAR_MAX
  always_comb begin
    case (step_q)
      NEAR_HOLD: stepped = near_o;
      NEAR_UP:   stepped = (near_o >= NEAR_CEIL) ? NEAR_CEIL : near_o + 1'b1;
      NEAR_DOWN: stepped = (near_o == '0) ? '0 : near_o - 1'b1;
      default:   stepped = '0;
    endcase
  end

  // block start reloads from table
  // stepping only on even ratios
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      near_q <= '0;
    end else if (en_fst_blo_i) begin
      near_q <= table_near;
    end else if (upmode_q && !ratio_q[0]) begin
      near_q <= stepped;
    end
  end

  // command and threshold copy taken at each strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q      <= NEAR_HOLD;
      near_snap_q <= '0;
    end else if (en_i) begin
      step_q      <= up_mode_i;
      near_snap_q <= near_o;
    end
  end

  // live value inside a block, frozen copy outside
  assign near_o = en_block_cnt_i ? near_q : near_snap_q;

  a_near_ceiling: assert property (@(posedge clk) disable iff (!rst_n) near_o <= NEAR_CEIL)
    else $error("threshold %0d above ceiling %0d", near_o, NEAR_CEIL);

endmodule

// ==== src/output_stage.sv ====
module output_stage
  import residual_pkg::*;
#(
  parameter int SAMPLE_W = residual_pkg::SAMPLE_W
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en_i,
  input  logic [SAMPLE_W-1:0] s_i,
  input  residual_t           res_i,
  input  logic [SAMPLE_W-1:0] pred_i,
  input  img_class_e          img_class_i,
  output logic [SAMPLE_W-1:0] s_o,
  output logic [SAMPLE_W-1:0] alpha_o,
  output logic                sgn_alpha_o,
  output logic [SAMPLE_W-1:0] pred_o,
  output img_class_e          img_class_q_o,
  output logic                en_cj_o
);

  logic [SAMPLE_W-1:0] s_q;
  residual_t           res_q;
  logic [SAMPLE_W-1:0] pred_q;
  logic                en_q;
  img_class_e          class_q;

  // payload for the reconstruction stage
  always_ff @(posedge clk) begin
    if (en_i) begin
      s_q    <= s_i;
      res_q  <= res_i;
      pred_q <= pred_i;
    end
  end

  // strobe delay and class feedback
  // class drops to none the cycle after a burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q    <= 1'b0;
      class_q <= CLS_NONE;
    end else begin
      en_q <= en_i;
      if (en_i) begin
        class_q <= img_class_i;
      end else if (en_q) begin
        class_q <= CLS_NONE;
      end
    end
  end

  assign s_o           = s_q;
  assign alpha_o       = res_q.mag;
  assign sgn_alpha_o   = res_q.sign;
  assign pred_o        = pred_q;
  assign img_class_q_o = class_q;
  assign en_cj_o       = en_q;

  // feedback must select a single candidate or none
  a_class_onehot0: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(class_q))
    else $error("class feedback not zero or one-hot: %b", class_q);

endmodule

// ==== src/predictor_select.sv ====
module predictor_select
  import residual_pkg::*;
#(
  parameter int SAMPLE_W = residual_pkg::SAMPLE_W
) (
  input  logic                clk,
  input  logic                rst_n,
  input  depth_mode_e         mode_i,
  input  cand_vec_t           vec1_i,
  input  cand_vec_t           vec2_i,
  input  cand_vec_t           vec3_i,
  input  logic [DELTA_W-1:0]  delta_i,
  input  img_class_e          img_class_q_i,
  output logic [SAMPLE_W-1:0] pred_o
);

  // quad-scale sum width, two bits above the divided prediction
  localparam int QUAD_W = PRED_W + 2;

  depth_mode_e         mode_q;
  cand_vec_t           cand;
  logic [QUAD_W-1:0]   quad;
  logic [QUAD_W-1:0]   quad_sum;
  logic [PRED_W-1:0]   pred_div;
  logic [SAMPLE_W-1:0] depth_max;

  // mode change takes effect one cycle late
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_q <= DEPTH_16;
    end else begin
      mode_q <= mode_i;
    end
  end

  // candidate picked by class of previous sample
  always_comb begin
    case (img_class_q_i)
      CLS_POS: cand = vec2_i;
      CLS_NEG: cand = vec3_i;
      default: cand = vec1_i;
    endcase
  end

  // sign bit on top of the used field
  assign quad = {cand[VEC_W-1], cand[VEC_LSB+QUAD_W-2:VEC_LSB]};

  // delta is an unsigned quarter-scale offset
  assign quad_sum = quad + {{(QUAD_W-DELTA_W){1'b0}}, delta_i};

  // drop two lsbs, keeps the sign
  assign pred_div = quad_sum[QUAD_W-1:2];

  // largest legal sample for the active depth
  always_comb begin
    case (mode_q)
      DEPTH_12: depth_max = {SAMPLE_W{1'b1}} >> (SAMPLE_W - 12);
      DEPTH_14: depth_max = {SAMPLE_W{1'b1}} >> (SAMPLE_W - 14);
      default:  depth_max = {SAMPLE_W{1'b1}};
    endcase
  end

  // negative to zero, over range to full scale
  always_comb begin
    if (pred_div[PRED_W-1]) begin
      pred_o = '0;
    end else if (pred_div[PRED_W-2:0] > {1'b0, depth_max}) begin
      pred_o = depth_max;
    end else begin
      pred_o = pred_div[SAMPLE_W-1:0];
    end
  end

  // mode input must stay a legal depth
  a_mode_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(mode_q))
    else $error("registered depth mode not one-hot: %b", mode_q);

endmodule

// ==== src/residual_map.sv ====
module residual_map
  import residual_pkg::*;
#(
  parameter int SAMPLE_W = residual_pkg::SAMPLE_W
) (
  input  logic [SAMPLE_W-1:0] s_i,
  input  logic [SAMPLE_W-1:0] pred_i,
  input  logic [NEAR_W-1:0]   near_i,
  input  logic                spec_fst_i,
  output residual_t           res_o,
  output img_class_e          img_class_o
);

  logic [SAMPLE_W:0]   diff;
  logic                sign;
  logic [SAMPLE_W-1:0] mag;
  logic [SAMPLE_W-1:0] near_ext;

  // one guard bit holds the sign of sample minus prediction
  assign diff = {1'b0, s_i} - {1'b0, pred_i};
  assign sign = diff[SAMPLE_W];

  // magnitude by two's complement when negative
  always_comb begin
    if (sign) begin
      mag = ~diff[SAMPLE_W-1:0] + 1'b1;
    end else begin
      mag = diff[SAMPLE_W-1:0];
    end
  end

  assign res_o.sign = sign;
  assign res_o.mag  = mag;

  // threshold widened to magnitude width
  assign near_ext = {{(SAMPLE_W-NEAR_W){1'b0}}, near_i};

  // first sample of a band is always small
  // within threshold counts as small too
  always_comb begin
    if (spec_fst_i) begin
      img_class_o = CLS_SMALL;
    end else if (mag > near_ext) begin
      if (sign) begin
        img_class_o = CLS_NEG;
      end else begin
        img_class_o = CLS_POS;
      end
    end else begin
      img_class_o = CLS_SMALL;
    end
  end

endmodule

// ==== src/residual_pkg.sv ====
package residual_pkg;

  // sample and residual magnitude width
  parameter int SAMPLE_W = 16;
  // quarter-scale correction width
  parameter int DELTA_W  = SAMPLE_W + 2;
  // candidate vector layout
  parameter int VEC_W    = 49;
  parameter int VEC_LSB  = 12;
  // signed prediction after divide by four
  parameter int PRED_W   = SAMPLE_W + 2;
  // near-lossless threshold
  parameter int NEAR_W   = 8;
  parameter int NEAR_MAX = 32;
  // compression ratio id
  parameter int RATIO_W  = 4;

  // one-hot sample depth
  typedef enum logic [2:0] {
    DEPTH_12 = 3'b001,
    DEPTH_14 = 3'b010,
    DEPTH_16 = 3'b100
  } depth_mode_e;

  // threshold step command, other codes clear the threshold
  typedef enum logic [2:0] {
    NEAR_HOLD = 3'd0,
    NEAR_UP   = 3'd1,
    NEAR_DOWN = 3'd2
  } near_step_e;

  // one-hot sample class, none between bursts
  typedef enum logic [2:0] {
    CLS_NONE  = 3'b000,
    CLS_SMALL = 3'b001,
    CLS_POS   = 3'b010,
    CLS_NEG   = 3'b100
  } img_class_e;

  // residual in sign and magnitude form
  typedef struct packed {
    logic                sign;
    logic [SAMPLE_W-1:0] mag;
  } residual_t;

  // candidate vector, quad-scale prediction is msb plus the bits from VEC_LSB
  typedef logic [VEC_W-1:0] cand_vec_t;

endpackage

// ==== src/residual_top.sv ====
module residual_top
  import residual_pkg::*;
#(
  parameter int SAMPLE_W = residual_pkg::SAMPLE_W,
  parameter int NEAR_MAX = residual_pkg::NEAR_MAX
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en_i,
  input  depth_mode_e         mode_i,
  input  logic [SAMPLE_W-1:0] s_i,
  input  logic [DELTA_W-1:0]  delta_i,
  input  cand_vec_t           vec1_i,
  input  cand_vec_t           vec2_i,
  input  cand_vec_t           vec3_i,
  input  logic                spec_fst_i,
  input  near_step_e          up_mode_i,
  input  logic                en_upmode_i,
  input  logic [RATIO_W-1:0]  id_ratio_i,
  input  logic                en_block_cnt_i,
  input  logic                en_fst_blo_i,
  output img_class_e          sgn_img_o,
  output img_class_e          sgn_img_r_o,
  output logic [SAMPLE_W-1:0] s_o,
  output logic [NEAR_W-1:0]   quant_near_o,
  output logic [SAMPLE_W-1:0] alpha_o,
  output logic                sgn_alpha_o,
  output logic [SAMPLE_W-1:0] vec_sl_ad_delta_o,
  output logic                en_cj_o
);

  // clamped prediction of the current sample
  logic [SAMPLE_W-1:0] pred;
  residual_t           res;

  // prediction, picks candidate from fed-back class
  predictor_select #(.SAMPLE_W(SAMPLE_W)) u_pred (
    .clk           (clk),
    .rst_n         (rst_n),
    .mode_i        (mode_i),
    .vec1_i        (vec1_i),
    .vec2_i        (vec2_i),
    .vec3_i        (vec3_i),
    .delta_i       (delta_i),
    .img_class_q_i (sgn_img_r_o),
    .pred_o        (pred)
  );

  // residual and class, same cycle as the sample
  residual_map #(.SAMPLE_W(SAMPLE_W)) u_map (
    .s_i         (s_i),
    .pred_i      (pred),
    .near_i      (quant_near_o),
    .spec_fst_i  (spec_fst_i),
    .res_o       (res),
    .img_class_o (sgn_img_o)
  );

  // near-lossless threshold
  near_control #(.SAMPLE_W(SAMPLE_W), .NEAR_MAX(NEAR_MAX)) u_near (
    .clk            (clk),
    .rst_n          (rst_n),
    .en_i           (en_i),
    .id_ratio_i     (id_ratio_i),
    .en_upmode_i    (en_upmode_i),
    .up_mode_i      (up_mode_i),
    .en_fst_blo_i   (en_fst_blo_i),
    .en_block_cnt_i (en_block_cnt_i),
    .near_o         (quant_near_o)
  );

  // stage two registers toward reconstruction
  output_stage #(.SAMPLE_W(SAMPLE_W)) u_out (
    .clk           (clk),
    .rst_n         (rst_n),
    .en_i          (en_i),
    .s_i           (s_i),
    .res_i         (res),
    .pred_i        (pred),
    .img_class_i   (sgn_img_o),
    .s_o           (s_o),
    .alpha_o       (alpha_o),
    .sgn_alpha_o   (sgn_alpha_o),
    .pred_o        (vec_sl_ad_delta_o),
    .img_class_q_o (sgn_img_r_o),
    .en_cj_o       (en_cj_o)
  );

endmodule

// ==== verif/tb_residual_tests.svh ====
// outputs right after reset release
task automatic verify_reset();
  @(negedge clk);
  check_val("en_cj_o", 0, en_cj_o);
  check_val("sgn_img_r_o", CLS_NONE, sgn_img_r_o);
  check_val("quant_near_o", 0, quant_near_o);
endtask

// same vector on all candidates, so the class feedback is irrelevant
task automatic predict_and_residual(depth_mode_e m);
  int        i;
  int        quad;
  int        delta;
  int        smp;
  int        span;
  int        pred;
  int        diff;
  cand_vec_t v;
  // sums land below zero and over range within the quad-scale span
  span = 4 << depth_bits(m);
  @(posedge clk);
  mode_i <= m;
  for (i = 0; i < N_PRED; i++) begin
    quad  = int'($unsigned($random(seed)) % (2 * span)) - span / 2;
    // correction scaled to the depth so every clamp case occurs
    delta = int'($unsigned($random(seed)) % (span / 4));
    smp   = int'($unsigned($random(seed)) % (1 << depth_bits(m)));
    v     = make_vec(quad);
    @(posedge clk);
    en_i    <= 1'b1;
    s_i     <= SAMPLE_W'(smp);
    delta_i <= DELTA_W'(delta);
    vec1_i  <= v;
    vec2_i  <= v;
    vec3_i  <= v;
    @(posedge clk);
    en_i <= 1'b0;
    @(negedge clk);
    pred = ref_pred(quad, delta, m);
    diff = smp - pred;
    check_val("vec_sl_ad_delta_o", pred, vec_sl_ad_delta_o);
    check_val("alpha_o", (diff < 0) ? -diff : diff, alpha_o);
    check_val("sgn_alpha_o", diff < 0, sgn_alpha_o);
    check_val("s_o", smp, s_o);
    check_val("en_cj_o", 1, en_cj_o);
  end
endtask

// ratio settles for two edges before block start loads it
task automatic load_table(int ratio, int expected);
  @(posedge clk);
  en_block_cnt_i <= 1'b1;
  en_upmode_i    <= 1'b0;
  id_ratio_i     <= RATIO_W'(ratio);
  repeat (2) @(posedge clk);
  en_fst_blo_i <= 1'b1;
  @(posedge clk);
  en_fst_blo_i <= 1'b0;
  @(negedge clk);
  check_val("quant_near_o", expected, quant_near_o);
  exp_near = expected;
endtask

task automatic load_ratio_table();
  load_table(1, 0);
  load_table(4, 8);
  load_table(8, 20);
endtask

task automatic classify_one(int smp, bit spec, int pred);
  @(posedge clk);
  s_i        <= SAMPLE_W'(smp);
  spec_fst_i <= spec;
  @(negedge clk);
  check_val("sgn_img_o", ref_class(smp, pred, exp_near, spec), sgn_img_o);
endtask

// residual at, above and below the threshold for both signs
task automatic classify_near_edges();
  int        i;
  int        pred;
  int        offs[6];
  cand_vec_t v;
  offs = '{8, 9, 7, -8, -9, -7};
  load_table(4, 8);
  pred = 2000;
  v    = make_vec(4 * pred);
  @(posedge clk);
  mode_i  <= DEPTH_16;
  delta_i <= '0;
  vec1_i  <= v;
  vec2_i  <= v;
  vec3_i  <= v;
  for (i = 0; i < 6; i++) begin
    classify_one(pred + offs[i], 1'b0, pred);
  end
  // band start wins over a large residual
  classify_one(pred + 9, 1'b1, pred);
  classify_one(pred - 9, 1'b1, pred);
  @(posedge clk);
  spec_fst_i <= 1'b0;
endtask

// strobe latches the command and up-enable stays high for count edges
task automatic step_near(near_step_e cmd, int count, bit active);
  @(posedge clk);
  en_i      <= 1'b1;
  up_mode_i <= cmd;
  @(posedge clk);
  en_i        <= 1'b0;
  en_upmode_i <= 1'b1;
  repeat (count) @(posedge clk);
  en_upmode_i <= 1'b0;
  @(posedge clk);
  @(negedge clk);
  if (active && cmd == NEAR_UP) begin
    exp_near = (exp_near + count > NEAR_MAX) ? NEAR_MAX : exp_near + count;
  end else if (active && cmd == NEAR_DOWN) begin
    exp_near = (exp_near - count < 0) ? 0 : exp_near - count;
  end
  check_val("quant_near_o", exp_near, quant_near_o);
endtask

task automatic step_rules();
  load_table(4, 8);
  step_near(NEAR_UP, 3, 1'b1);
  step_near(NEAR_DOWN, 1, 1'b1);
  // runs into the floor
  step_near(NEAR_DOWN, 15, 1'b1);
  // runs into the ceiling
  step_near(NEAR_UP, 40, 1'b1);
  // start between floor and ceiling so either direction would move
  load_table(8, 20);
  // odd ratio freezes the value
  @(posedge clk);
  id_ratio_i <= RATIO_W'(5);
  repeat (2) @(posedge clk);
  step_near(NEAR_DOWN, 3, 1'b0);
  step_near(NEAR_UP, 2, 1'b0);
endtask

// back to back strobes where the previous class picks the next candidate
task automatic select_candidates();
  int         k;
  int         preds[3];
  int         offs[8];
  int         pred;
  int         last_pred;
  int         smp;
  img_class_e prev;
  img_class_e cls;
  preds = '{1000, 3000, 5000};
  offs  = '{50, -50, 3, -50, 50, 50, -2, -50};
  load_table(4, 8);
  @(posedge clk);
  vec1_i  <= make_vec(4 * preds[0]);
  vec2_i  <= make_vec(4 * preds[1]);
  vec3_i  <= make_vec(4 * preds[2]);
  delta_i <= '0;
  prev      = CLS_NONE;
  last_pred = 0;
  for (k = 0; k < 8; k++) begin
    case (prev)
      CLS_POS: pred = preds[1];
      CLS_NEG: pred = preds[2];
      default: pred = preds[0];
    endcase
    smp = pred + offs[k];
    cls = ref_class(smp, pred, exp_near, 1'b0);
    @(posedge clk);
    en_i <= 1'b1;
    s_i  <= SAMPLE_W'(smp);
    @(negedge clk);
    check_val("sgn_img_o", cls, sgn_img_o);
    check_val("sgn_img_r_o", prev, sgn_img_r_o);
    if (k > 0) begin
      check_val("vec_sl_ad_delta_o", last_pred, vec_sl_ad_delta_o);
    end
    last_pred = pred;
    prev      = cls;
  end
  @(posedge clk);
  en_i <= 1'b0;
  @(negedge clk);
  check_val("vec_sl_ad_delta_o", last_pred, vec_sl_ad_delta_o);
  check_val("sgn_img_r_o", prev, sgn_img_r_o);
  // class clears once the burst is over
  @(posedge clk);
  @(negedge clk);
  check_val("sgn_img_r_o", CLS_NONE, sgn_img_r_o);
endtask

// ==== verif/tb_residual.sv ====
module tb_residual
  import residual_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  // random strobes per depth
  localparam int N_PRED     = 24;
  // rough cycle count of each test, setup edges included
  localparam int RESET_CYC  = 12;
  localparam int PRED_CYC   = 3 * (3 * N_PRED + 2);
  localparam int TABLE_CYC  = 3 * 6;
  localparam int CLASS_CYC  = 6 + 10;
  localparam int STEP_CYC   = 6 + 64 + 6 * 4 + 3;
  localparam int SEL_CYC    = 6 + 8 + 4;
  localparam int WATCHDOG_CYC = RESET_CYC + PRED_CYC + TABLE_CYC + CLASS_CYC
                              + STEP_CYC + SEL_CYC + 50;

  logic                clk;
  logic                rst_n;
  logic                en_i;
  depth_mode_e         mode_i;
  logic [SAMPLE_W-1:0] s_i;
  logic [DELTA_W-1:0]  delta_i;
  cand_vec_t           vec1_i;
  cand_vec_t           vec2_i;
  cand_vec_t           vec3_i;
  logic                spec_fst_i;
  near_step_e          up_mode_i;
  logic                en_upmode_i;
  logic [RATIO_W-1:0]  id_ratio_i;
  logic                en_block_cnt_i;
  logic                en_fst_blo_i;
  img_class_e          sgn_img_o;
  img_class_e          sgn_img_r_o;
  logic [SAMPLE_W-1:0] s_o;
  logic [NEAR_W-1:0]   quant_near_o;
  logic [SAMPLE_W-1:0] alpha_o;
  logic                sgn_alpha_o;
  logic [SAMPLE_W-1:0] vec_sl_ad_delta_o;
  logic                en_cj_o;

  int seed = 32'hacbc_9e35;
  int fail_count;
  // threshold the model expects right now
  int exp_near;

  residual_top UUT (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic end_with_fail();
    fail_count++;
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      end_with_fail();
    end
  endtask

  function automatic int depth_bits(depth_mode_e m);
    case (m)
      DEPTH_12: return 12;
      DEPTH_14: return 14;
      default:  return 16;
    endcase
  endfunction

  // quad-scale sum over four, negative to zero, clipped at full scale
  function automatic int ref_pred(int quad, int delta, depth_mode_e m);
    int sum;
    int top;
    sum = quad + delta;
    top = (1 << depth_bits(m)) - 1;
    if (sum < 0) return 0;
    if (sum / 4 > top) return top;
    return sum / 4;
  endfunction

  function automatic img_class_e ref_class(int smp, int pred, int near, bit spec);
    int mag;
    mag = (smp >= pred) ? smp - pred : pred - smp;
    if (spec || mag <= near) return CLS_SMALL;
    if (smp < pred) return CLS_NEG;
    return CLS_POS;
  endfunction

  // random filler, only sign bit and field from VEC_LSB carry the value
  function automatic cand_vec_t make_vec(int quad);
    cand_vec_t   v;
    logic [19:0] q;
    q = quad[19:0];
    v = cand_vec_t'({$random(seed), $random(seed)});
    v[VEC_W-1] = q[19];
    v[VEC_LSB+18:VEC_LSB] = q[18:0];
    return v;
  endfunction

  `include "tb_residual_tests.svh"

  initial begin
    fail_count     = 0;
    exp_near       = 0;
    rst_n          = 1'b0;
    en_i           = 1'b0;
    mode_i         = DEPTH_16;
    s_i            = '0;
    delta_i        = '0;
    vec1_i         = '0;
    vec2_i         = '0;
    vec3_i         = '0;
    spec_fst_i     = 1'b0;
    up_mode_i      = NEAR_HOLD;
    en_upmode_i    = 1'b0;
    id_ratio_i     = RATIO_W'(1);
    en_block_cnt_i = 1'b0;
    en_fst_blo_i   = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    verify_reset();
    predict_and_residual(DEPTH_12);
    predict_and_residual(DEPTH_14);
    predict_and_residual(DEPTH_16);
    load_ratio_table();
    classify_near_edges();
    step_rules();
    select_candidates();
    if (fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      end_with_fail();
    end
  end

  // hard stop if a test hangs
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
    end_with_fail();
  end

endmodule
